// File: hw/csr_pkg.sv
/*
 * Machine-mode CSR definitions
 * Addresses, funct3 operation codes, mstatus field positions, fixed
 * identification values and the two-view CSR address word
 */
`default_nettype none

package csr_pkg;

  // ======================================================================
  // Widths
  // ======================================================================
  localparam int XLEN       = 32;                 // Register width
  localparam int CSR_ADDR_W = 12;                 // CSR address width

  // ======================================================================
  // CSR addresses
  // ======================================================================
  // Trap setup
  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MISA      = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE       = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC     = 12'h305;
  // Trap handling
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH  = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL     = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP       = 12'h344;
  // Identification, read-only by encoding
  localparam logic [CSR_ADDR_W-1:0] CSR_MVENDORID = 12'hF11;
  localparam logic [CSR_ADDR_W-1:0] CSR_MARCHID   = 12'hF12;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIMPID    = 12'hF13;
  localparam logic [CSR_ADDR_W-1:0] CSR_MHARTID   = 12'hF14;

  // Operation codes as in funct3
  localparam logic [2:0] CSR_RW  = 3'b001;
  localparam logic [2:0] CSR_RS  = 3'b010;
  localparam logic [2:0] CSR_RC  = 3'b011;
  localparam logic [2:0] CSR_RWI = 3'b101;
  localparam logic [2:0] CSR_RSI = 3'b110;
  localparam logic [2:0] CSR_RCI = 3'b111;

  // Privilege levels
  localparam logic [1:0] PRIV_U = 2'b00;
  localparam logic [1:0] PRIV_M = 2'b11;

  // ======================================================================
  // mstatus layout and fixed values
  // ======================================================================
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;
  localparam int MSTATUS_MPP_MSB  = 12;

  // MPP starts in machine mode
  localparam logic [XLEN-1:0] MSTATUS_RESET =
    {{(XLEN-MSTATUS_MPP_MSB-1){1'b0}}, PRIV_M, {MSTATUS_MPP_LSB{1'b0}}};

  localparam logic [XLEN-1:0] MISA_VALUE   = {2'b01, 4'b0000, 26'h000_1129}; // MXL=1, IMAFD
  localparam logic [XLEN-1:0] MIMPID_VALUE = 32'h0000_0001;

  // Same 12-bit address seen whole or split per the privileged spec
  typedef union packed {
    logic [CSR_ADDR_W-1:0] raw;
    struct packed {
      logic [1:0] ro_bits;                        // 11 marks read-only space
      logic [1:0] priv_level;                     // Lowest privilege allowed
      logic [7:0] index;
    } field;
  } csr_addr_u;

endpackage

`default_nettype wire

// File: hw/csr_decode.sv
/*
 * CSR access decode
 * Flags illegal accesses and forms the value a CSR instruction writes
 */
`timescale 1ns/1ns
`default_nettype none

module csr_decode import csr_pkg::*; (
  input  logic [CSR_ADDR_W-1:0] csr_addr,
  input  logic [2:0]            csr_op,
  input  logic [XLEN-1:0]       csr_wdata,    // rs1 or zero-extended uimm
  input  logic                  csr_we,
  input  logic                  csr_access,
  input  logic [1:0]            current_priv,
  input  logic [XLEN-1:0]       rdata,        // Current value from read mux
  output logic                  illegal_csr,
  output logic                  wr_en,
  output logic [XLEN-1:0]       wr_data
);

  csr_addr_u addr_u;
  logic      csr_exists;
  logic      priv_ok;
  logic      read_only;

  assign addr_u.raw = csr_addr;

  // ======================================================================
  // Legality
  // ======================================================================
  always_comb begin
    case (addr_u.raw)
      CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC,
      CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
      CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID:
        csr_exists = 1'b1;
      default:
        csr_exists = 1'b0;                  // Unknown address
    endcase
  end

  assign priv_ok   = (current_priv >= addr_u.field.priv_level);
  // misa is implemented read-only even though it sits in RW space
  assign read_only = (addr_u.field.ro_bits == 2'b11) || (addr_u.raw == CSR_MISA);

  assign illegal_csr = csr_access &&
                       (!csr_exists || !priv_ok || (csr_we && read_only));

  // Illegal writes change nothing
  assign wr_en = csr_access && csr_we && !illegal_csr;

  // ======================================================================
  // Write value
  // ======================================================================
  always_comb begin
    case (csr_op)
      CSR_RW, CSR_RWI: wr_data = csr_wdata;              // Replace
      CSR_RS, CSR_RSI: wr_data = rdata | csr_wdata;      // Set bits
      CSR_RC, CSR_RCI: wr_data = rdata & ~csr_wdata;     // Clear bits
      default:         wr_data = rdata;                  // Hold
    endcase
  end

endmodule

`default_nettype wire

// File: hw/csr_status_reg.sv
/*
 * mstatus register
 * Keeps MIE, MPIE and MPP and runs the trap and MRET interrupt stack
 */
`timescale 1ns/1ns
`default_nettype none

module csr_status_reg import csr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [CSR_ADDR_W-1:0] csr_addr,
  input  logic                  wr_en,        // Legal write this cycle
  input  logic [XLEN-1:0]       wr_data,
  input  logic                  trap_entry,
  input  logic                  mret,
  input  logic [1:0]            current_priv,
  output logic [XLEN-1:0]       mstatus_value,
  output logic                  mstatus_mie,
  output logic                  mstatus_mpie,
  output logic [1:0]            mpp_out
);

  logic       mie_q;
  logic       mpie_q;
  logic [1:0] mpp_q;

  // Priority is trap, then MRET, then CSR write
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie_q  <= MSTATUS_RESET[MSTATUS_MIE_BIT];
      mpie_q <= MSTATUS_RESET[MSTATUS_MPIE_BIT];
      mpp_q  <= MSTATUS_RESET[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB];   // M-mode
    end else if (trap_entry) begin
      mpie_q <= mie_q;                        // Stack enable
      mie_q  <= 1'b0;                         // Mask interrupts in handler
      mpp_q  <= current_priv;
    end else if (mret) begin
      mie_q  <= mpie_q;                       // Unstack enable
      mpie_q <= 1'b1;
      mpp_q  <= PRIV_U;                       // Least privileged mode
    end else if (wr_en && (csr_addr == CSR_MSTATUS)) begin
      // Only the three kept fields load
      mie_q  <= wr_data[MSTATUS_MIE_BIT];
      mpie_q <= wr_data[MSTATUS_MPIE_BIT];
      mpp_q  <= wr_data[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB];
    end
  end

  // ======================================================================
  // Read view and outputs
  // ======================================================================
  always_comb begin
    mstatus_value                                  = '0;     // Unkept bits read 0
    mstatus_value[MSTATUS_MIE_BIT]                 = mie_q;
    mstatus_value[MSTATUS_MPIE_BIT]                = mpie_q;
    mstatus_value[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB] = mpp_q;
  end

  assign mstatus_mie  = mie_q;
  assign mstatus_mpie = mpie_q;
  assign mpp_out      = mpp_q;

  // Core never retires MRET in a trapping cycle
  a_no_trap_and_mret: assert property (
    @(posedge clk) disable iff (!reset_n) !(trap_entry && mret)
  ) else $error("trap_entry and mret high together");

endmodule

`default_nettype wire

// File: hw/csr_machine_regs.sv
/*
 * Machine trap registers
 * mie, mip, mtvec, mscratch, mepc, mcause and mtval with write alignment
 * and capture of the trap PC, cause and value
 */
`timescale 1ns/1ns
`default_nettype none

module csr_machine_regs import csr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [CSR_ADDR_W-1:0] csr_addr,
  input  logic                  wr_en,
  input  logic [XLEN-1:0]       wr_data,
  input  logic                  trap_entry,
  input  logic [XLEN-1:0]       trap_pc,
  input  logic [4:0]            trap_cause,
  input  logic [XLEN-1:0]       trap_val,
  output logic [XLEN-1:0]       mie_value,
  output logic [XLEN-1:0]       mip_value,
  output logic [XLEN-1:0]       mtvec_value,
  output logic [XLEN-1:0]       mscratch_value,
  output logic [XLEN-1:0]       mepc_value,
  output logic [XLEN-1:0]       mcause_value,
  output logic [XLEN-1:0]       mtval_value
);

  logic [XLEN-1:0] mie_q;
  logic [XLEN-1:0] mip_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mtval_q;

  // ======================================================================
  // Register update
  // ======================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mie_q      <= '0;
      mip_q      <= '0;
      mtvec_q    <= '0;                       // Handler at address 0
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else if (trap_entry) begin
      // Trap wins over any write in the same cycle
      mepc_q   <= trap_pc;
      mcause_q <= {{(XLEN-5){1'b0}}, trap_cause};   // Exceptions only
      mtval_q  <= trap_val;
    end else if (wr_en) begin
      case (csr_addr)
        CSR_MIE:      mie_q      <= wr_data;
        CSR_MIP:      mip_q      <= wr_data;
        CSR_MTVEC:    mtvec_q    <= {wr_data[XLEN-1:2], 2'b00};  // Direct mode, word aligned
        CSR_MSCRATCH: mscratch_q <= wr_data;
        CSR_MEPC:     mepc_q     <= {wr_data[XLEN-1:1], 1'b0};   // Halfword aligned for RVC
        CSR_MCAUSE:   mcause_q   <= wr_data;
        CSR_MTVAL:    mtval_q    <= wr_data;
        default: ;                            // Not ours
      endcase
    end
  end

  assign mie_value      = mie_q;
  assign mip_value      = mip_q;
  assign mtvec_value    = mtvec_q;
  assign mscratch_value = mscratch_q;
  assign mepc_value     = mepc_q;
  assign mcause_value   = mcause_q;
  assign mtval_value    = mtval_q;

  // Trap vector handed to fetch stays word aligned
  a_mtvec_aligned: assert property (
    @(posedge clk) disable iff (!reset_n) mtvec_value[1:0] == 2'b00
  ) else $error("mtvec low bits set");

endmodule

`default_nettype wire

// File: hw/csr_read_mux.sv
/*
 * CSR read select
 * Returns the addressed register or constant, zero when unknown
 */
`timescale 1ns/1ns
`default_nettype none

module csr_read_mux import csr_pkg::*; (
  input  logic [CSR_ADDR_W-1:0] csr_addr,
  input  logic [XLEN-1:0]       mstatus_value,
  input  logic [XLEN-1:0]       mie_value,
  input  logic [XLEN-1:0]       mip_value,
  input  logic [XLEN-1:0]       mtvec_value,
  input  logic [XLEN-1:0]       mscratch_value,
  input  logic [XLEN-1:0]       mepc_value,
  input  logic [XLEN-1:0]       mcause_value,
  input  logic [XLEN-1:0]       mtval_value,
  output logic [XLEN-1:0]       rdata
);

  // ======================================================================
  // Address select
  // ======================================================================
  always_comb begin
    case (csr_addr)
      CSR_MSTATUS:   rdata = mstatus_value;
      CSR_MISA:      rdata = MISA_VALUE;        // Fixed ISA string
      CSR_MIE:       rdata = mie_value;
      CSR_MTVEC:     rdata = mtvec_value;
      CSR_MSCRATCH:  rdata = mscratch_value;
      CSR_MEPC:      rdata = mepc_value;
      CSR_MCAUSE:    rdata = mcause_value;
      CSR_MTVAL:     rdata = mtval_value;
      CSR_MIP:       rdata = mip_value;
      CSR_MIMPID:    rdata = MIMPID_VALUE;
      // Vendor, architecture and single hart all report zero
      CSR_MVENDORID,
      CSR_MARCHID,
      CSR_MHARTID:   rdata = '0;
      default:       rdata = '0;                // Unknown address
    endcase
  end

endmodule

`default_nettype wire

// File: hw/csr_unit.sv
/*
 * Machine-mode CSR unit
 * Single-cycle CSR access with legality check, trap entry and MRET
 */
`timescale 1ns/1ns
`default_nettype none

module csr_unit import csr_pkg::*; (
  input  logic                  clk,
  input  logic                  reset_n,
  input  logic [CSR_ADDR_W-1:0] csr_addr,
  input  logic [XLEN-1:0]       csr_wdata,
  input  logic [2:0]            csr_op,
  input  logic                  csr_we,
  input  logic                  csr_access,
  input  logic [1:0]            current_priv,
  input  logic                  trap_entry,
  input  logic [XLEN-1:0]       trap_pc,
  input  logic [4:0]            trap_cause,
  input  logic [XLEN-1:0]       trap_val,
  input  logic                  mret,
  output logic [XLEN-1:0]       csr_rdata,
  output logic                  illegal_csr,
  output logic [XLEN-1:0]       trap_vector,    // mtvec
  output logic [XLEN-1:0]       mepc_out,
  output logic                  mstatus_mie,
  output logic                  mstatus_mpie,
  output logic [1:0]            mpp_out
);

  logic            wr_en;
  logic [XLEN-1:0] wr_data;
  logic [XLEN-1:0] mstatus_value;
  logic [XLEN-1:0] mie_value;
  logic [XLEN-1:0] mip_value;
  logic [XLEN-1:0] mscratch_value;
  logic [XLEN-1:0] mcause_value;
  logic [XLEN-1:0] mtval_value;

  // ======================================================================
  // Decode and registers
  // ======================================================================
  csr_decode u_decode (
    .csr_addr     (csr_addr),
    .csr_op       (csr_op),
    .csr_wdata    (csr_wdata),
    .csr_we       (csr_we),
    .csr_access   (csr_access),
    .current_priv (current_priv),
    .rdata        (csr_rdata),          // Old value for set and clear
    .illegal_csr  (illegal_csr),
    .wr_en        (wr_en),
    .wr_data      (wr_data)
  );

  csr_status_reg u_status (
    .clk           (clk),
    .reset_n       (reset_n),
    .csr_addr      (csr_addr),
    .wr_en         (wr_en),
    .wr_data       (wr_data),
    .trap_entry    (trap_entry),
    .mret          (mret),
    .current_priv  (current_priv),
    .mstatus_value (mstatus_value),
    .mstatus_mie   (mstatus_mie),
    .mstatus_mpie  (mstatus_mpie),
    .mpp_out       (mpp_out)
  );

  csr_machine_regs u_mregs (
    .clk            (clk),
    .reset_n        (reset_n),
    .csr_addr       (csr_addr),
    .wr_en          (wr_en),
    .wr_data        (wr_data),
    .trap_entry     (trap_entry),
    .trap_pc        (trap_pc),
    .trap_cause     (trap_cause),
    .trap_val       (trap_val),
    .mie_value      (mie_value),
    .mip_value      (mip_value),
    .mtvec_value    (trap_vector),      // Also the trap target
    .mscratch_value (mscratch_value),
    .mepc_value     (mepc_out),         // Also the MRET target
    .mcause_value   (mcause_value),
    .mtval_value    (mtval_value)
  );

  csr_read_mux u_rmux (
    .csr_addr       (csr_addr),
    .mstatus_value  (mstatus_value),
    .mie_value      (mie_value),
    .mip_value      (mip_value),
    .mtvec_value    (trap_vector),
    .mscratch_value (mscratch_value),
    .mepc_value     (mepc_out),
    .mcause_value   (mcause_value),
    .mtval_value    (mtval_value),
    .rdata          (csr_rdata)
  );

endmodule

`default_nettype wire

// File: tests/tb_csr_unit.sv
/*
 * Testbench for the machine-mode CSR unit
 * Shadow model of the CSRs, checked against the DUT by concurrent assertions
 */
`timescale 1ns/1ns
`default_nettype none

module tb_csr_unit import csr_pkg::*; ();

  localparam int MAX_CYCLES = 2000;   // Stimulus runs about 550 cycles
  localparam logic [CSR_ADDR_W-1:0] CSR_LIST [13] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE,
    CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP,
    CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID};
  localparam logic [2:0] OP_LIST [6] = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};

  logic clk = 1'b0;
  logic reset_n;
  logic [CSR_ADDR_W-1:0] csr_addr;
  logic [XLEN-1:0] csr_wdata, trap_pc, trap_val;
  logic [2:0] csr_op;
  logic csr_we, csr_access, trap_entry, mret;
  logic [1:0] current_priv;
  logic [4:0] trap_cause;
  logic [XLEN-1:0] csr_rdata, trap_vector, mepc_out;
  logic illegal_csr, mstatus_mie, mstatus_mpie;
  logic [1:0] mpp_out;

  int seed = 40643;
  int errors = 0;
  int cycles = 0;

  // Shadow state
  logic m_mie, m_mpie;
  logic [1:0] m_mpp;
  logic [XLEN-1:0] r_mie, r_mip, r_mtvec, r_mscratch, r_mepc, r_mcause, r_mtval;
  logic [XLEN-1:0] exp_rdata, exp_wdata;
  logic exp_known, exp_illegal;

  always #2 clk = ~clk;                       // 4 ns period

  csr_unit dut (.*);

  // ====================================================================
  // Reference model
  // ====================================================================
  always_comb begin
    exp_known = 1'b1;
    exp_rdata = '0;
    case (csr_addr)
      CSR_MSTATUS: begin
        exp_rdata[MSTATUS_MIE_BIT]                 = m_mie;
        exp_rdata[MSTATUS_MPIE_BIT]                = m_mpie;
        exp_rdata[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB] = m_mpp;
      end
      CSR_MISA:     exp_rdata = MISA_VALUE;
      CSR_MIE:      exp_rdata = r_mie;
      CSR_MTVEC:    exp_rdata = r_mtvec;
      CSR_MSCRATCH: exp_rdata = r_mscratch;
      CSR_MEPC:     exp_rdata = r_mepc;
      CSR_MCAUSE:   exp_rdata = r_mcause;
      CSR_MTVAL:    exp_rdata = r_mtval;
      CSR_MIP:      exp_rdata = r_mip;
      CSR_MIMPID:   exp_rdata = MIMPID_VALUE;
      CSR_MVENDORID, CSR_MARCHID, CSR_MHARTID: exp_rdata = '0;
      default:      exp_known = 1'b0;
    endcase
    // Bits 9:8 give the lowest privilege, 11:10 == 11 marks read-only space
    exp_illegal = csr_access && (!exp_known || (current_priv < csr_addr[9:8]) ||
                  (csr_we && (csr_addr[11:10] == 2'b11 || csr_addr == CSR_MISA)));
    case (csr_op)
      CSR_RW, CSR_RWI: exp_wdata = csr_wdata;
      CSR_RS, CSR_RSI: exp_wdata = exp_rdata | csr_wdata;
      CSR_RC, CSR_RCI: exp_wdata = exp_rdata & ~csr_wdata;
      default:         exp_wdata = exp_rdata;
    endcase
  end

  // Trap over MRET over CSR write
  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      {m_mie, m_mpie, m_mpp} <= {1'b0, 1'b0, PRIV_M};
      {r_mie, r_mip, r_mtvec, r_mscratch} <= '0;
      {r_mepc, r_mcause, r_mtval} <= '0;
    end else if (trap_entry) begin
      r_mepc   <= trap_pc;
      r_mcause <= {27'd0, trap_cause};
      r_mtval  <= trap_val;
      m_mpie   <= m_mie;
      m_mie    <= 1'b0;
      m_mpp    <= current_priv;
    end else if (mret) begin
      {m_mie, m_mpie, m_mpp} <= {m_mpie, 1'b1, PRIV_U};
    end else if (csr_access && csr_we && !exp_illegal) begin
      case (csr_addr)
        CSR_MSTATUS: begin
          m_mie  <= exp_wdata[MSTATUS_MIE_BIT];
          m_mpie <= exp_wdata[MSTATUS_MPIE_BIT];
          m_mpp  <= exp_wdata[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB];
        end
        CSR_MIE:      r_mie      <= exp_wdata;
        CSR_MIP:      r_mip      <= exp_wdata;
        CSR_MTVEC:    r_mtvec    <= {exp_wdata[31:2], 2'b00};   // Word aligned
        CSR_MSCRATCH: r_mscratch <= exp_wdata;
        CSR_MEPC:     r_mepc     <= {exp_wdata[31:1], 1'b0};
        CSR_MCAUSE:   r_mcause   <= exp_wdata;
        CSR_MTVAL:    r_mtval    <= exp_wdata;
        default: ;
      endcase
    end
  end

  // ====================================================================
  // Checks
  // ====================================================================
  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
  endtask

  a_rdata: assert property (@(posedge clk) disable iff (!reset_n) csr_rdata == exp_rdata)
    else report_mismatch("csr_rdata", $sampled(csr_rdata), $sampled(exp_rdata));
  a_illegal: assert property (@(posedge clk) disable iff (!reset_n) illegal_csr == exp_illegal)
    else report_mismatch("illegal_csr", $sampled(illegal_csr), $sampled(exp_illegal));
  a_vector: assert property (@(posedge clk) disable iff (!reset_n) trap_vector == r_mtvec)
    else report_mismatch("trap_vector", $sampled(trap_vector), $sampled(r_mtvec));
  a_mepc: assert property (@(posedge clk) disable iff (!reset_n) mepc_out == r_mepc)
    else report_mismatch("mepc_out", $sampled(mepc_out), $sampled(r_mepc));
  a_mie: assert property (@(posedge clk) disable iff (!reset_n) mstatus_mie == m_mie)
    else report_mismatch("mstatus_mie", $sampled(mstatus_mie), $sampled(m_mie));
  a_mpie: assert property (@(posedge clk) disable iff (!reset_n) mstatus_mpie == m_mpie)
    else report_mismatch("mstatus_mpie", $sampled(mstatus_mpie), $sampled(m_mpie));
  a_mpp: assert property (@(posedge clk) disable iff (!reset_n) mpp_out == m_mpp)
    else report_mismatch("mpp_out", $sampled(mpp_out), $sampled(m_mpp));

  // ====================================================================
  // Stimulus, one cycle per task call
  // ====================================================================
  task automatic drive_access(input logic [11:0] addr, input logic [2:0] op,
                              input logic [31:0] data, input logic we, input logic [1:0] priv);
    @(posedge clk);
    {csr_access, csr_we, trap_entry, mret} <= {1'b1, we, 1'b0, 1'b0};
    csr_addr     <= addr;
    csr_op       <= op;
    csr_wdata    <= data;
    current_priv <= priv;
  endtask

  task automatic read_csr(input logic [11:0] addr);
    drive_access(addr, CSR_RS, 32'd0, 1'b0, PRIV_M);      // Plain read
  endtask

  // Trap with a competing mepc write in the same cycle
  task automatic drive_trap(input logic [1:0] priv);
    @(posedge clk);
    {csr_access, csr_we, trap_entry, mret} <= 4'b1110;
    {csr_addr, csr_op, current_priv} <= {CSR_MEPC, CSR_RW, priv};
    csr_wdata  <= $random(seed);
    trap_pc    <= $random(seed);
    trap_cause <= $random(seed);
    trap_val   <= $random(seed);
  endtask

  task automatic drive_mret();
    @(posedge clk);
    {csr_access, csr_we, trap_entry, mret} <= 4'b0001;
    current_priv <= PRIV_M;
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] rnd;
    reset_n <= 1'b0;
    {csr_access, csr_we, trap_entry, mret} <= 4'b0000;
    {csr_addr, csr_op, csr_wdata} <= '0;
    {trap_pc, trap_cause, trap_val} <= '0;
    current_priv <= PRIV_M;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
    foreach (CSR_LIST[i]) read_csr(CSR_LIST[i]);          // Reset values
    // All six operations on mscratch, immediates zero-extended
    for (int n = 0; n < 32; n++) begin
      foreach (OP_LIST[k]) begin
        rnd = $random(seed);
        if (OP_LIST[k][2]) rnd = {27'd0, rnd[4:0]};
        drive_access(CSR_MSCRATCH, OP_LIST[k], rnd, 1'b1, PRIV_M);
        read_csr(CSR_MSCRATCH);
      end
    end
    // Field masks and alignment
    for (int n = 0; n < 8; n++) begin
      drive_access(CSR_MTVEC, CSR_RW, $random(seed), 1'b1, PRIV_M);
      read_csr(CSR_MTVEC);
      drive_access(CSR_MEPC, CSR_RW, $random(seed), 1'b1, PRIV_M);
      read_csr(CSR_MEPC);
      drive_access(CSR_MSTATUS, CSR_RW, $random(seed), 1'b1, PRIV_M);
      read_csr(CSR_MSTATUS);
    end
    // Legality, each followed by a read of the target
    drive_access(12'h7C0, CSR_RS, 32'd0, 1'b0, PRIV_M);
    drive_access(12'h345, CSR_RW, $random(seed), 1'b1, PRIV_M);
    drive_access(CSR_MSCRATCH, CSR_RW, $random(seed), 1'b1, PRIV_U);
    drive_access(CSR_MSTATUS, CSR_RS, 32'd0, 1'b0, PRIV_U);
    read_csr(CSR_MSCRATCH);
    drive_access(CSR_MIMPID, CSR_RW, $random(seed), 1'b1, PRIV_M);
    read_csr(CSR_MIMPID);
    drive_access(CSR_MISA, CSR_RS, 32'hFFFF_FFFF, 1'b1, PRIV_M);
    read_csr(CSR_MISA);
    foreach (CSR_LIST[i]) read_csr(CSR_LIST[i]);
    // Traps from both modes, each closed by MRET
    drive_access(CSR_MTVEC, CSR_RW, 32'h8000_0103, 1'b1, PRIV_M);
    for (int n = 0; n < 8; n++) begin
      drive_access(CSR_MSTATUS, CSR_RW, $random(seed), 1'b1, PRIV_M);
      drive_trap(n[0] ? PRIV_M : PRIV_U);
      read_csr(CSR_MEPC);
      read_csr(CSR_MCAUSE);
      read_csr(CSR_MTVAL);
      read_csr(CSR_MSTATUS);
      drive_mret();
      read_csr(CSR_MSTATUS);
    end
    @(posedge clk);
    {csr_access, csr_we} <= 2'b00;
    repeat (3) @(posedge clk);
    #1;
    $display("Checks done after %0d cycles with %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_status_reg.sv
hw/csr_machine_regs.sv
hw/csr_read_mux.sv
hw/csr_unit.sv
tests/tb_csr_unit.sv
